/* logic/adc_pkg.sv */
// ADC controller shared definitions
// Register opcodes, engine states, bus and frame records, constants

package adc_pkg;

  // ------------------------------------------------------------
  // Constants
  // ------------------------------------------------------------
  localparam int          FRAME_BITS    = 16;
  localparam logic [15:0] ADC_ID        = 16'h0ADC;
  // Upper half of a PROGRAM write that launches a program frame
  localparam logic [15:0] CMD_NEW_VALUE = 16'h0001;
  // Bound set by the 3-bit channel tag in each frame
  localparam int          MAX_CHANNELS  = 8;

  // ------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------
  // Register opcodes from the low address nibble
  typedef enum logic [3:0] {
    OVERFLOW = 4'h1,
    DIVIDE   = 4'h2,
    ENDTIME  = 4'h3,
    PROGRAM  = 4'h4,
    SAMPLE   = 4'h7,
    SEQUENCE = 4'h8,
    ID_REG   = 4'h9,
    BUSY     = 4'hA,
    LAST     = 4'hB
  } reg_op_e;

  typedef enum logic [1:0] {
    IDLE,
    PROGRAM_ADC,
    ACQUIRE,
    COPY
  } engine_state_e;

  // ------------------------------------------------------------
  // Records
  // ------------------------------------------------------------
  typedef struct packed {
    logic [7:0]  chan;
    reg_op_e     op;
    logic [31:0] wdata;
    logic        wr;
    logic        re;
  } bus_req_t;

  typedef struct packed {
    logic [15:0] overflow;
    logic [31:0] end_time;
  } chan_cfg_t;

  // Tag is the top three bits of the frame
  typedef struct packed {
    logic [2:0]  chan;
    logic [15:0] word;
  } frame_t;

endpackage

/* logic/adc_reg_bank.sv */
// ADC register bank
// Decodes host bus requests into per-channel configuration, the clock
// divider and converter commands, and returns registered read data

`timescale 1ns/1ps

module adc_reg_bank #(
  parameter int NUM_CHANNELS = adc_pkg::MAX_CHANNELS
) (
  input  logic                clk,
  input  logic                reset,
  input  adc_pkg::bus_req_t   bus_req,
  input  logic [15:0]         sample_rd [NUM_CHANNELS],
  input  logic [15:0]         seq_rd [NUM_CHANNELS],
  input  logic                busy,
  input  logic                prog_done,
  input  logic [15:0]         prog_word,
  output logic [15:0]         data_out,
  output logic                rd_valid,
  output adc_pkg::chan_cfg_t  cfg [NUM_CHANNELS],
  output logic [15:0]         divide,
  output logic                cmd_valid,
  output logic [15:0]         cmd_word
);
  import adc_pkg::*;

  logic        in_range;
  logic [2:0]  idx;
  logic [15:0] last_cmd;
  logic [15:0] rd_mux;

  // Channel field doubles as the select; out of range means ignore
  assign in_range = (bus_req.chan < NUM_CHANNELS);
  assign idx      = bus_req.chan[2:0];

  // ------------------------------------------------------------
  // Write side
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        cfg[c] <= '0;
      end
      divide    <= '0;
      cmd_valid <= 1'b0;
      cmd_word  <= '0;
    end else begin
      // Command strobe lasts one cycle
      cmd_valid <= 1'b0;
      if (bus_req.wr && in_range) begin
        case (bus_req.op)
          OVERFLOW: cfg[idx].overflow <= bus_req.wdata[15:0];
          ENDTIME:  cfg[idx].end_time <= bus_req.wdata;
          DIVIDE:   divide            <= bus_req.wdata[15:0];
          PROGRAM: begin
            // Only a tagged command word reaches the converter
            if (bus_req.wdata[31:16] == CMD_NEW_VALUE) begin
              cmd_valid <= 1'b1;
              cmd_word  <= bus_req.wdata[15:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Last word actually shifted out to the converter
  always_ff @(posedge clk) begin
    if (reset) begin
      last_cmd <= '0;
    end else if (prog_done) begin
      last_cmd <= prog_word;
    end
  end

  // ------------------------------------------------------------
  // Read side
  // ------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    if (in_range) begin
      case (bus_req.op)
        SAMPLE:   rd_mux = sample_rd[idx];
        SEQUENCE: rd_mux = seq_rd[idx];
        ID_REG:   rd_mux = ADC_ID;
        BUSY:     rd_mux = {15'd0, busy};
        LAST:     rd_mux = last_cmd;
        default:  rd_mux = '0;
      endcase
    end
  end

  // Answer one cycle after re, out-of-range reads answer zero
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      data_out <= '0;
    end else begin
      rd_valid <= bus_req.re;
      data_out <= bus_req.re ? rd_mux : 16'd0;
    end
  end

endmodule

/* logic/adc_serial_engine.sv */
// ADC serial engine
// Divides the serial clock from clk and runs 16-bit program and
// acquire frames over chip select, serial clock and the data lines

`timescale 1ns/1ps

module adc_serial_engine (
  input  logic             clk,
  input  logic             reset,
  input  logic [15:0]      divide,
  input  logic             cmd_valid,
  input  logic [15:0]      cmd_word,
  input  logic             adc_dout,
  output logic             adc_cs,
  output logic             adc_sclk,
  output logic             adc_din,
  output logic             busy,
  output logic             frame_valid,
  output adc_pkg::frame_t  frame,
  output logic             prog_done,
  output logic [15:0]      prog_word
);
  import adc_pkg::*;

  localparam int CNT_W = $clog2(FRAME_BITS);

  engine_state_e         state;
  logic                  pend_valid;
  logic [15:0]           pend_word;
  logic [15:0]           phase_cnt;
  logic                  half;
  logic [CNT_W-1:0]      bit_cnt;
  logic [FRAME_BITS-1:0] shift_out;
  logic [FRAME_BITS-1:0] shift_in;
  logic                  in_frame;
  logic                  phase_end;
  logic                  bit_end;
  logic                  last_bit;

  assign in_frame  = (state == PROGRAM_ADC) || (state == ACQUIRE);
  // Compare with >= so a divider lowered mid-frame cannot overrun
  assign phase_end = (phase_cnt >= divide);
  assign bit_end   = in_frame && half && phase_end;
  assign last_bit  = (bit_cnt == CNT_W'(FRAME_BITS - 1));

  // ------------------------------------------------------------
  // Pending command, newest wins
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_valid <= 1'b0;
      pend_word  <= '0;
    end else if (cmd_valid) begin
      pend_valid <= 1'b1;
      pend_word  <= cmd_word;
    end else if (state == IDLE && pend_valid) begin
      pend_valid <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // Bit timing
  // ------------------------------------------------------------
  // Each half bit lasts divide+1 cycles, low half first
  always_ff @(posedge clk) begin
    if (reset || !in_frame) begin
      phase_cnt <= '0;
      half      <= 1'b0;
      bit_cnt   <= '0;
    end else if (phase_end) begin
      phase_cnt <= '0;
      half      <= ~half;
      if (half) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Frame sequencing
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      prog_done <= 1'b0;
    end else begin
      prog_done <= 1'b0;
      case (state)
        // Pending command takes priority over conversions
        IDLE: state <= pend_valid ? PROGRAM_ADC : ACQUIRE;
        PROGRAM_ADC: begin
          if (bit_end && last_bit) begin
            state     <= IDLE;
            prog_done <= 1'b1;
          end
        end
        ACQUIRE: begin
          if (bit_end && last_bit) begin
            state <= COPY;
          end
        end
        COPY: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Shift registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_out <= '0;
      shift_in  <= '0;
      prog_word <= '0;
    end else begin
      if (state == IDLE && pend_valid) begin
        shift_out <= pend_word;
        prog_word <= pend_word;
      end else if (bit_end) begin
        // Next bit appears as the low half of the new bit starts
        shift_out <= {shift_out[FRAME_BITS-2:0], 1'b0};
      end
      // Capture on the edge where sclk goes high
      if (state == ACQUIRE && !half && phase_end) begin
        shift_in <= {shift_in[FRAME_BITS-2:0], adc_dout};
      end
    end
  end

  assign adc_cs      = ~in_frame;
  assign adc_sclk    = in_frame & half;
  // Data line held low outside program frames
  assign adc_din     = (state == PROGRAM_ADC) & shift_out[FRAME_BITS-1];
  assign busy        = (state != ACQUIRE);
  assign frame_valid = (state == COPY);
  assign frame       = '{chan: shift_in[FRAME_BITS-1 -: 3], word: shift_in};

endmodule

/* logic/adc_frame_store.sv */
// ADC frame store
// Routes each finished conversion frame by its channel tag into one
// holding register per channel

`timescale 1ns/1ps

module adc_frame_store #(
  parameter int NUM_CHANNELS = adc_pkg::MAX_CHANNELS
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             frame_valid,
  input  adc_pkg::frame_t  frame,
  output logic [15:0]      holding [NUM_CHANNELS]
);

  // ------------------------------------------------------------
  // Per-channel holding registers
  // ------------------------------------------------------------
  // Tags beyond the configured count match no register and are dropped
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_hold
    logic hit;

    // Tag decode for this channel
    assign hit = frame_valid && (frame.chan == 3'(c));

    always_ff @(posedge clk) begin
      if (reset) begin
        holding[c] <= '0;
      end else if (hit) begin
        // Whole frame kept, tag bits included
        holding[c] <= frame.word;
      end
    end
  end

endmodule

/* logic/adc_rate_gate.sv */
// ADC rate gate
// Per-channel decimation counters copy holding values into sample
// registers and count sequence numbers; strobed sample port with
// end-time gating

`timescale 1ns/1ps

module adc_rate_gate #(
  parameter int NUM_CHANNELS = adc_pkg::MAX_CHANNELS
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [15:0]         holding [NUM_CHANNELS],
  input  adc_pkg::chan_cfg_t  cfg [NUM_CHANNELS],
  input  logic                output_sample,
  input  logic [7:0]          channel_select,
  input  logic [31:0]         current_time,
  output logic [15:0]         sample_rd [NUM_CHANNELS],
  output logic [15:0]         seq_rd [NUM_CHANNELS],
  output logic                sample_valid,
  output logic [31:0]         sample_data
);

  logic       sel_ok;
  logic [2:0] sel;

  // ------------------------------------------------------------
  // Decimation counters
  // ------------------------------------------------------------
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    logic [15:0] count;
    logic        enabled;
    logic        match;

    // Overflow of zero parks the channel
    assign enabled = (cfg[c].overflow != 16'd0);
    assign match   = enabled && (count >= cfg[c].overflow);

    always_ff @(posedge clk) begin
      if (reset) begin
        count        <= 16'd1;
        sample_rd[c] <= '0;
        seq_rd[c]    <= '0;
      end else if (match) begin
        // Reload, take the latest frame, bump the sequence
        count        <= 16'd1;
        sample_rd[c] <= holding[c];
        seq_rd[c]    <= seq_rd[c] + 16'd1;
      end else if (enabled) begin
        count <= count + 16'd1;
      end
    end
  end

  // ------------------------------------------------------------
  // Sample port
  // ------------------------------------------------------------
  assign sel_ok = (channel_select < NUM_CHANNELS);
  assign sel    = channel_select[2:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
      sample_data  <= '0;
    end else begin
      sample_valid <= output_sample && sel_ok;
      if (output_sample && sel_ok) begin
        // All ones until system time passes the channel end time
        if (current_time > cfg[sel].end_time) begin
          sample_data <= {seq_rd[sel], sample_rd[sel]};
        end else begin
          sample_data <= 32'hFFFF_FFFF;
        end
      end
    end
  end

endmodule

/* logic/adc_subsystem.sv */
// ADC controller subsystem
// Register bank, serial engine, frame store and rate gate in a chain

`timescale 1ns/1ps

module adc_subsystem #(
  parameter int NUM_CHANNELS = adc_pkg::MAX_CHANNELS
) (
  input  logic               clk,
  input  logic               reset,
  input  adc_pkg::bus_req_t  bus_req,
  output logic [15:0]        data_out,
  output logic               rd_valid,
  input  logic               output_sample,
  input  logic [7:0]         channel_select,
  input  logic [31:0]        current_time,
  output logic [31:0]        sample_data,
  output logic               sample_valid,
  output logic               adc_cs,
  output logic               adc_sclk,
  output logic               adc_din,
  input  logic               adc_dout
);
  import adc_pkg::*;

  // ------------------------------------------------------------
  // Stage wiring
  // ------------------------------------------------------------
  chan_cfg_t   cfg [NUM_CHANNELS];
  logic [15:0] divide;
  logic        cmd_valid;
  logic [15:0] cmd_word;
  logic        busy;
  logic        prog_done;
  logic [15:0] prog_word;
  logic        frame_valid;
  frame_t      frame;
  logic [15:0] holding [NUM_CHANNELS];
  logic [15:0] sample_rd [NUM_CHANNELS];
  logic [15:0] seq_rd [NUM_CHANNELS];

  adc_reg_bank #(.NUM_CHANNELS(NUM_CHANNELS)) reg_bank_inst (
    .clk       (clk),
    .reset     (reset),
    .bus_req   (bus_req),
    .sample_rd (sample_rd),
    .seq_rd    (seq_rd),
    .busy      (busy),
    .prog_done (prog_done),
    .prog_word (prog_word),
    .data_out  (data_out),
    .rd_valid  (rd_valid),
    .cfg       (cfg),
    .divide    (divide),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word)
  );

  adc_serial_engine serial_engine_inst (
    .clk         (clk),
    .reset       (reset),
    .divide      (divide),
    .cmd_valid   (cmd_valid),
    .cmd_word    (cmd_word),
    .adc_dout    (adc_dout),
    .adc_cs      (adc_cs),
    .adc_sclk    (adc_sclk),
    .adc_din     (adc_din),
    .busy        (busy),
    .frame_valid (frame_valid),
    .frame       (frame),
    .prog_done   (prog_done),
    .prog_word   (prog_word)
  );

  adc_frame_store #(.NUM_CHANNELS(NUM_CHANNELS)) frame_store_inst (
    .clk         (clk),
    .reset       (reset),
    .frame_valid (frame_valid),
    .frame       (frame),
    .holding     (holding)
  );

  adc_rate_gate #(.NUM_CHANNELS(NUM_CHANNELS)) rate_gate_inst (
    .clk            (clk),
    .reset          (reset),
    .holding        (holding),
    .cfg            (cfg),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .current_time   (current_time),
    .sample_rd      (sample_rd),
    .seq_rd         (seq_rd),
    .sample_valid   (sample_valid),
    .sample_data    (sample_data)
  );

endmodule

/* test/adc_chk.sv */
// ADC serial engine assertions
// Frame length, strobe exclusion and idle serial clock, bound into the engine

`timescale 1ns/1ps

module adc_chk (
  input logic        clk,
  input logic        reset,
  input logic [15:0] divide,
  input logic        adc_cs,
  input logic        adc_sclk,
  input logic        frame_valid,
  input logic        prog_done
);

  int          fail_count = 0;
  logic [31:0] low_len;
  logic [15:0] div_start;
  logic        div_moved;

  // Cycles with chip select low, and the divider seen when the frame began
  always_ff @(posedge clk) begin
    if (reset || adc_cs) begin
      low_len   <= '0;
      div_start <= divide;
      div_moved <= 1'b0;
    end else begin
      low_len <= low_len + 32'd1;
      if (divide != div_start) begin
        div_moved <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Frame length is 16 bits of 2*(divide+1) cycles
  a_cs_len: assert property (@(posedge clk) disable iff (reset)
    ($rose(adc_cs) && !div_moved) |-> (low_len == (32'(div_start) + 32'd1) * 32'd32))
    else begin
      $error("chip select low for %0d cycles with divide %0d", low_len, div_start);
      fail_count++;
    end

  // Program and acquire completions never share a cycle
  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(frame_valid && prog_done))
    else begin
      $error("frame_valid and prog_done high together");
      fail_count++;
    end

  // Serial clock rests low between frames
  a_sclk_idle: assert property (@(posedge clk) disable iff (reset)
    adc_cs |-> !adc_sclk)
    else begin
      $error("adc_sclk high while adc_cs is high");
      fail_count++;
    end

endmodule

bind adc_serial_engine adc_chk chk_inst (
  .clk         (clk),
  .reset       (reset),
  .divide      (divide),
  .adc_cs      (adc_cs),
  .adc_sclk    (adc_sclk),
  .frame_valid (frame_valid),
  .prog_done   (prog_done)
);

/* test/adc_scoreboard.sv */
// ADC scoreboard
// Watches read, sample and din traffic and counts mismatches

`timescale 1ns/1ps

module adc_scoreboard #(
  parameter int NUM_CHANNELS = adc_pkg::MAX_CHANNELS
) (
  input  logic              clk,
  input  logic              reset,
  input  adc_pkg::bus_req_t bus_req,
  input  logic [15:0]       data_out,
  input  logic              rd_valid,
  input  logic              output_sample,
  input  logic [7:0]        channel_select,
  input  logic [31:0]       sample_data,
  input  logic              sample_valid,
  input  logic [1:0]        exp_mode,
  input  logic [15:0]       exp_value,
  input  logic [1:0]        exp_smode,
  input  logic [15:0]       exp_low,
  input  logic [15:0]       din_word,
  input  logic              din_done,
  output int                errors
);
  import adc_pkg::*;

  // Read check modes, then sample check modes
  localparam logic [1:0] M_ABS   = 2'd1;
  localparam logic [1:0] M_DELTA = 2'd2;
  localparam logic [1:0] S_ONES  = 2'd1;
  localparam logic [1:0] S_PAIR  = 2'd2;

  int          err_count = 0;
  logic        rd_pend;
  logic [1:0]  mode_q;
  logic [15:0] val_q;
  reg_op_e     op_q;
  logic [15:0] prev_rd;
  logic [15:0] din_cmd;
  logic        smp_pend;
  logic [1:0]  smode_q;
  logic [15:0] low_q;

  assign errors = err_count;

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    err_count++;
  endtask

  task automatic fault(input string msg);
    $display("Check failed at %0t: %s", $time, msg);
    err_count++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      rd_pend  <= 1'b0;
      smp_pend <= 1'b0;
      prev_rd  <= '0;
      din_cmd  <= '0;
    end else begin
      // ------------------------------------------------------------
      // Register reads answer one cycle after re
      if (rd_valid != rd_pend) begin
        fault("rd_valid did not follow re by exactly one cycle");
      end
      if (rd_valid && rd_pend) begin
        if (mode_q == M_ABS && data_out != val_q) begin
          mismatch("data_out", 32'(data_out), 32'(val_q));
        end
        // The word read back as LAST must also have gone out on din
        if (mode_q == M_ABS && op_q == LAST && din_cmd != val_q) begin
          mismatch("adc_din frame", 32'(din_cmd), 32'(val_q));
        end
        if (mode_q == M_DELTA && data_out != 16'(prev_rd + val_q)) begin
          mismatch("data_out", 32'(data_out), 32'(16'(prev_rd + val_q)));
        end
        prev_rd <= data_out;
      end
      rd_pend <= bus_req.re;
      mode_q  <= exp_mode;
      val_q   <= exp_value;
      op_q    <= bus_req.op;

      // ------------------------------------------------------------
      // Sample port answers one cycle after an in-range strobe
      if (sample_valid != smp_pend) begin
        fault("sample_valid did not match the sample strobe one cycle earlier");
      end
      if (sample_valid && smp_pend) begin
        if (smode_q == S_ONES && sample_data != 32'hFFFF_FFFF) begin
          mismatch("sample_data", sample_data, 32'hFFFF_FFFF);
        end
        if (smode_q == S_PAIR) begin
          if (!rd_valid) begin
            fault("no SEQUENCE read answered alongside the sample");
          end else if (sample_data != {data_out, low_q}) begin
            mismatch("sample_data", sample_data, {data_out, low_q});
          end
        end
      end
      smp_pend <= output_sample && (channel_select < NUM_CHANNELS);
      smode_q  <= exp_smode;
      low_q    <= exp_low;

      // Acquire frames hold din low, so a nonzero word is a program frame
      if (din_done && din_word != 16'd0) begin
        din_cmd <= din_word;
      end
    end
  end

endmodule

/* test/adc_tb.sv */
// ADC subsystem testbench
// Clock, reset, table-driven bus and sample stimulus, serial converter
// model, watchdog and closing report

`timescale 1ns/1ps

module adc_tb;
  import adc_pkg::*;

  localparam int NUM_CH    = 8;
  localparam int DIV       = 1;
  // One frame plus its IDLE and COPY cycles
  localparam int FRAME_CYC = 32 * (DIV + 1) + 2;

  localparam logic [1:0] M_NONE  = 2'd0;
  localparam logic [1:0] M_ABS   = 2'd1;
  localparam logic [1:0] M_DELTA = 2'd2;
  localparam logic [1:0] S_NONE  = 2'd0;
  localparam logic [1:0] S_ONES  = 2'd1;
  localparam logic [1:0] S_PAIR  = 2'd2;
  localparam logic [1:0] S_NOANS = 2'd3;

  // One table entry, bus request and sample strobe share the channel
  typedef struct packed {
    logic        use_bus;
    reg_op_e     op;
    logic [7:0]  chan;
    logic [31:0] wdata;
    logic [1:0]  mode;
    logic [15:0] expv;
    logic [1:0]  smode;
    logic [31:0] stime;
    logic [15:0] wait_cyc;
  } step_t;

  logic        clk;
  logic        reset;
  bus_req_t    bus_req;
  logic [15:0] data_out;
  logic        rd_valid;
  logic        output_sample;
  logic [7:0]  channel_select;
  logic [31:0] current_time;
  logic [31:0] sample_data;
  logic        sample_valid;
  logic        adc_cs;
  logic        adc_sclk;
  logic        adc_din;
  logic        adc_dout;
  logic [1:0]  exp_mode;
  logic [15:0] exp_value;
  logic [1:0]  exp_smode;
  logic [15:0] exp_low;
  logic [15:0] din_word;
  logic        din_done;
  int          sb_errors;
  logic [15:0] words [NUM_CH];
  step_t       steps [$];
  logic        built;
  // Converter model state
  logic        cs_q;
  logic        sclk_q;
  logic [15:0] model_word;
  int          bit_idx;
  int          next_chan;

  adc_subsystem #(.NUM_CHANNELS(NUM_CH)) adc_subsystem_inst (
    .clk            (clk),
    .reset          (reset),
    .bus_req        (bus_req),
    .data_out       (data_out),
    .rd_valid       (rd_valid),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .current_time   (current_time),
    .sample_data    (sample_data),
    .sample_valid   (sample_valid),
    .adc_cs         (adc_cs),
    .adc_sclk       (adc_sclk),
    .adc_din        (adc_din),
    .adc_dout       (adc_dout)
  );

  adc_scoreboard #(.NUM_CHANNELS(NUM_CH)) scoreboard_inst (
    .clk            (clk),
    .reset          (reset),
    .bus_req        (bus_req),
    .data_out       (data_out),
    .rd_valid       (rd_valid),
    .output_sample  (output_sample),
    .channel_select (channel_select),
    .sample_data    (sample_data),
    .sample_valid   (sample_valid),
    .exp_mode       (exp_mode),
    .exp_value      (exp_value),
    .exp_smode      (exp_smode),
    .exp_low        (exp_low),
    .din_word       (din_word),
    .din_done       (din_done),
    .errors         (sb_errors)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic is_write_op(input reg_op_e op);
    return (op == OVERFLOW) || (op == DIVIDE) || (op == ENDTIME) || (op == PROGRAM);
  endfunction

  task automatic add_step(input logic use_bus, input reg_op_e op, input logic [7:0] chan,
                          input logic [31:0] wdata, input logic [1:0] mode,
                          input logic [15:0] expv, input logic [1:0] smode,
                          input logic [31:0] stime, input int wait_cyc);
    steps.push_back(step_t'{use_bus, op, chan, wdata, mode, expv, smode, stime,
                            16'(wait_cyc)});
  endtask

  // ------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------
  task automatic build_table();
    add_step(1, DIVIDE, 0, DIV, M_NONE, 0, S_NONE, 0, 2);
    add_step(1, ID_REG, 0, 0, M_ABS, ADC_ID, S_NONE, 0, 2);
    add_step(1, ID_REG, NUM_CH, 0, M_ABS, 0, S_NONE, 0, 2);
    // Channel 7 stays disabled
    for (int c = 0; c < NUM_CH - 1; c++) begin
      add_step(1, OVERFLOW, 8'(c), 5, M_NONE, 0, S_NONE, 0, 0);
    end
    add_step(1, ENDTIME, 2, 1000, M_NONE, 0, S_NONE, 0, 0);
    add_step(1, PROGRAM, 0, {CMD_NEW_VALUE, 16'hA5C3}, M_NONE, 0, S_NONE, 0, FRAME_CYC);
    // Command waits at most one acquire frame, so this read lands in the program frame
    add_step(1, BUSY, 0, 0, M_ABS, 1, S_NONE, 0, 2 * FRAME_CYC - 1);
    add_step(1, LAST, 0, 0, M_ABS, 16'hA5C3, S_NONE, 0, 2);
    // Untagged upper half launches nothing
    add_step(1, PROGRAM, 0, 32'h0002_1234, M_NONE, 0, S_NONE, 0, 3 * FRAME_CYC);
    add_step(1, LAST, 0, 0, M_ABS, 16'hA5C3, S_NONE, 0, 2);
    // Both reads fall inside acquire frames
    add_step(1, BUSY, 0, 0, M_ABS, 0, S_NONE, 0, 7);
    add_step(1, BUSY, 0, 0, M_ABS, 0, S_NONE, 0, 11 * FRAME_CYC);
    for (int c = 0; c < NUM_CH; c++) begin
      add_step(1, SAMPLE, 8'(c), 0, M_ABS, (c < NUM_CH - 1) ? words[c] : 16'd0,
               S_NONE, 0, 0);
    end
    // Reads 10 and then 15 cycles apart with overflow 5
    add_step(1, SEQUENCE, 0, 0, M_NONE, 0, S_NONE, 0, 9);
    add_step(1, SEQUENCE, 0, 0, M_DELTA, 2, S_NONE, 0, 14);
    add_step(1, SEQUENCE, 0, 0, M_DELTA, 3, S_NONE, 0, 2);
    add_step(0, ID_REG, 2, 0, M_NONE, 0, S_ONES, 1000, 2);
    add_step(1, SEQUENCE, 2, 0, M_NONE, 0, S_PAIR, 1001, 2);
    add_step(0, ID_REG, NUM_CH, 0, M_NONE, 0, S_NOANS, 5000, 2);
    add_step(0, ID_REG, 7, 0, M_NONE, 0, S_ONES, 0, 4);
  endtask

  // Drive one entry on the falling edge, then idle for its wait
  task automatic apply_step(input step_t st);
    bus_req.chan   = st.chan;
    bus_req.op     = st.op;
    bus_req.wdata  = st.wdata;
    bus_req.wr     = st.use_bus && is_write_op(st.op);
    bus_req.re     = st.use_bus && !is_write_op(st.op);
    exp_mode       = st.mode;
    exp_value      = st.expv;
    exp_smode      = st.smode;
    exp_low        = words[st.chan[2:0]];
    output_sample  = (st.smode != S_NONE);
    channel_select = st.chan;
    current_time   = st.stime;
    @(negedge clk);
    bus_req.wr    = 1'b0;
    bus_req.re    = 1'b0;
    output_sample = 1'b0;
    exp_mode      = M_NONE;
    repeat (st.wait_cyc) @(negedge clk);
  endtask

  // ------------------------------------------------------------
  // Converter model, one table word per channel in turn
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (!adc_cs && cs_q) begin
      model_word = words[next_chan];
      bit_idx    = 15;
      adc_dout   = model_word[15];
      next_chan  = (next_chan + 1) % NUM_CH;
      din_word   = '0;
    end else if (!adc_cs && sclk_q && !adc_sclk && bit_idx > 0) begin
      bit_idx  = bit_idx - 1;
      adc_dout = model_word[bit_idx];
    end
    // Record din on each rising serial clock
    if (!adc_cs && adc_sclk && !sclk_q) begin
      din_word = {din_word[14:0], adc_din};
    end
    din_done = adc_cs && !cs_q;
    cs_q     = adc_cs;
    sclk_q   = adc_sclk;
  end

  // Watchdog sized from the table waits plus 20 frames
  initial begin
    int limit;
    wait (built);
    limit = 8 + 20 * FRAME_CYC + 20;
    foreach (steps[i]) begin
      limit += 1 + int'(steps[i].wait_cyc);
    end
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the table finished", limit);
    $display("Regression failed");
    $finish;
  end

  initial begin
    logic [31:0] seed;
    int          asrt;
    reset = 1'b1;
    bus_req = '0;
    output_sample = 1'b0;
    channel_select = '0;
    current_time = '0;
    adc_dout = 1'b0;
    exp_mode = M_NONE;
    exp_value = '0;
    exp_smode = S_NONE;
    exp_low = '0;
    din_word = '0;
    din_done = 1'b0;
    cs_q = 1'b1;
    sclk_q = 1'b0;
    model_word = '0;
    bit_idx = 0;
    next_chan = 0;
    built = 1'b0;
    // Frame word carries its channel tag in the top three bits
    seed = 32'habc6;
    for (int c = 0; c < NUM_CH; c++) begin
      seed = next_rand(seed);
      words[c] = {3'(c), seed[28:16]};
    end
    build_table();
    built = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    repeat (10) @(negedge clk);
    asrt = adc_subsystem_inst.serial_engine_inst.chk_inst.fail_count;
    $display("Checks done: %0d scoreboard errors, %0d assertion failures", sb_errors, asrt);
    if (sb_errors == 0 && asrt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* build.f */
logic/adc_pkg.sv
logic/adc_reg_bank.sv
logic/adc_serial_engine.sv
logic/adc_frame_store.sv
logic/adc_rate_gate.sv
logic/adc_subsystem.sv
test/adc_chk.sv
test/adc_scoreboard.sv
test/adc_tb.sv
